/* ray_consts.svh */
`ifndef RAY_CONSTS_SVH
`define RAY_CONSTS_SVH

// word width of every value.
`define RAY_WIDTH 32

// fraction bits of the q format.
`define RAY_Q_BITS 10

// entries in each fifo.
`define RAY_FIFO_DEPTH 16

`endif

/* ray_pkg.sv */
`include "ray_consts.svh"

package ray_pkg;

    // signed q10 word.
    typedef logic signed [`RAY_WIDTH-1:0] fix_t;

    typedef enum logic [1:0] {
        DIV_IDLE,  // waiting for operands.
        DIV_LOAD,  // take magnitudes.
        DIV_RUN,   // shift-subtract loop.
        DIV_DONE   // push result.
    } div_state_t;

endpackage

/* fifo_array.sv */
`include "ray_consts.svh"

module fifo_array import ray_pkg::*; #(
    parameter int FIFO_DATA_WIDTH  = `RAY_WIDTH,
    parameter int FIFO_BUFFER_SIZE = `RAY_FIFO_DEPTH,
    parameter int ARRAY_SIZE       = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic wr_en,
    input  fix_t din [ARRAY_SIZE-1:0],
    output logic full,
    input  logic rd_en,
    output fix_t dout [ARRAY_SIZE-1:0],
    output logic empty
);
    localparam int PTR_W = (FIFO_BUFFER_SIZE > 1) ? $clog2(FIFO_BUFFER_SIZE) : 1;
    localparam int CNT_W = $clog2(FIFO_BUFFER_SIZE + 1);

    logic [FIFO_DATA_WIDTH-1:0] mem [FIFO_BUFFER_SIZE-1:0][ARRAY_SIZE-1:0];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    assign full  = (count == CNT_W'(FIFO_BUFFER_SIZE));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;   // writes into a full fifo are dropped.
    assign do_rd = rd_en && !empty;

    always_comb begin
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            dout[i] = mem[rd_ptr][i];  // head shows while not empty.
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            for (int i = 0; i < ARRAY_SIZE; i++) begin
                mem[wr_ptr][i] <= din[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end
endmodule

/* dot.sv */
`include "ray_consts.svh"

module dot import ray_pkg::*; #(
    parameter int Q_BITS = `RAY_Q_BITS
) (
    input  logic clock,
    input  logic reset,
    input  fix_t x [2:0],
    input  fix_t y [2:0],
    input  logic in_empty,
    output logic in_rd_en,
    output fix_t out,
    output logic out_empty,
    input  logic out_rd_en
);
    localparam int DEPTH  = `RAY_FIFO_DEPTH;
    localparam int CRED_W = $clog2(DEPTH + 1);
    localparam int PROD_W = 2 * `RAY_WIDTH;

    logic signed [PROD_W-1:0] prod [2:0];
    logic signed [PROD_W-1:0] sum;
    logic s1_valid;
    logic s2_valid;
    fix_t s2_word [0:0];
    fix_t fifo_dout [0:0];
    logic fifo_full;
    logic [CRED_W-1:0] credit;

    // credit covers both stages and the fifo, so a pop always has a slot.
    assign in_rd_en = !in_empty && !fifo_full && (credit < CRED_W'(DEPTH));
    assign sum = prod[0] + prod[1] + prod[2];
    assign out = fifo_dout[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            credit   <= '0;
        end else begin
            s1_valid <= in_rd_en;
            s2_valid <= s1_valid;
            credit   <= credit + CRED_W'(in_rd_en) - CRED_W'(out_rd_en && !out_empty);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < 3; i++) begin
            prod[i] <= x[i] * y[i];           // full width product.
        end
        s2_word[0] <= fix_t'(sum >>> Q_BITS);  // truncating shift.
    end

    fifo_array #(.FIFO_DATA_WIDTH(`RAY_WIDTH), .ARRAY_SIZE(1)) u_out_fifo (
        .clock (clock),     .reset (reset),
        .wr_en (s2_valid),  .din   (s2_word),   .full  (fifo_full),
        .rd_en (out_rd_en), .dout  (fifo_dout), .empty (out_empty)
    );
endmodule

/* sub_single.sv */
`include "ray_consts.svh"

module sub_single import ray_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  fix_t x,
    input  fix_t y,
    input  logic in_empty,
    output logic in_rd_en,
    output fix_t out,
    output logic out_empty,
    input  logic out_rd_en
);
    localparam int DEPTH  = `RAY_FIFO_DEPTH;
    localparam int CRED_W = $clog2(DEPTH + 1);

    fix_t diff [0:0];
    fix_t fifo_dout [0:0];
    logic wr_pend;
    logic fifo_full;
    logic [CRED_W-1:0] credit;

    assign in_rd_en = !in_empty && !fifo_full && (credit < CRED_W'(DEPTH));  // pending word counts.
    assign out = fifo_dout[0];

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_pend <= 1'b0;
            credit  <= '0;
        end else begin
            wr_pend <= in_rd_en;
            credit  <= credit + CRED_W'(in_rd_en) - CRED_W'(out_rd_en && !out_empty);
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            diff[0] <= x - y;  // wraps at word width.
        end
    end

    fifo_array #(.FIFO_DATA_WIDTH(`RAY_WIDTH), .ARRAY_SIZE(1)) u_out_fifo (
        .clock (clock),     .reset (reset),
        .wr_en (wr_pend),   .din   (diff),      .full  (fifo_full),
        .rd_en (out_rd_en), .dout  (fifo_dout), .empty (out_empty)
    );
endmodule

/* divide_top.sv */
`include "ray_consts.svh"

module divide_top import ray_pkg::*; #(
    parameter int Q_BITS  = `RAY_Q_BITS,
    parameter int D_WIDTH = `RAY_WIDTH
) (
    input  logic clock,
    input  logic reset,
    input  fix_t dividend,
    input  fix_t divisor,
    input  logic in_empty,
    output logic in_rd_en,
    output fix_t out_dout,
    output logic out_empty,
    input  logic out_rd_en
);
    localparam int N     = D_WIDTH + Q_BITS;
    localparam int CNT_W = $clog2(N + 1);
    localparam logic [N-1:0] POS_MAX = {{(Q_BITS + 1){1'b0}}, {(D_WIDTH - 1){1'b1}}};
    localparam logic [N-1:0] NEG_MAX = POS_MAX + 1'b1;

    div_state_t state;
    logic [D_WIDTH-1:0] num_r;
    logic [D_WIDTH-1:0] den_r;
    logic [D_WIDTH-1:0] den_mag;
    logic [N-1:0] quo;
    logic [D_WIDTH:0] rem;
    logic [D_WIDTH:0] rem_shift;
    logic [CNT_W-1:0] count;
    logic neg;
    logic [D_WIDTH-1:0] result;
    fix_t fifo_din [0:0];
    fix_t fifo_dout [0:0];
    logic fifo_full;
    logic out_wr_en;

    function automatic logic [D_WIDTH-1:0] mag(input logic [D_WIDTH-1:0] v);
        return v[D_WIDTH-1] ? (~v + 1'b1) : v;
    endfunction

    assign in_rd_en  = (state == DIV_IDLE) && !in_empty;
    assign out_wr_en = (state == DIV_DONE) && !fifo_full;  // hold result until there is room.
    assign rem_shift = {rem[D_WIDTH-1:0], quo[N-1]};
    assign fifo_din[0] = fix_t'(result);
    assign out_dout = fifo_dout[0];

    // sign restore and saturation to the word range.
    always_comb begin
        if (neg) begin
            result = (quo >= NEG_MAX) ? {1'b1, {(D_WIDTH - 1){1'b0}}} : ~quo[D_WIDTH-1:0] + 1'b1;
        end else begin
            result = (quo > POS_MAX) ? POS_MAX[D_WIDTH-1:0] : quo[D_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (in_rd_en) begin
                        state <= DIV_LOAD;
                    end
                end
                DIV_LOAD: begin
                    state <= (den_r == '0) ? DIV_DONE : DIV_RUN;  // zero divisor skips loop.
                    count <= CNT_W'(N);
                end
                DIV_RUN: begin
                    count <= count - 1'b1;
                    if (count == CNT_W'(1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    if (out_wr_en) begin
                        state <= DIV_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            num_r <= dividend;
            den_r <= divisor;
        end
        if (state == DIV_LOAD) begin
            rem     <= '0;
            den_mag <= mag(den_r);
            if (den_r == '0) begin
                neg <= num_r[D_WIDTH-1];
                quo <= POS_MAX;
            end else begin
                neg <= num_r[D_WIDTH-1] ^ den_r[D_WIDTH-1];
                quo <= {mag(num_r), {Q_BITS{1'b0}}};  // dividend scaled by q.
            end
        end else if (state == DIV_RUN) begin
            if (rem_shift >= {1'b0, den_mag}) begin
                rem <= rem_shift - {1'b0, den_mag};
                quo <= {quo[N-2:0], 1'b1};
            end else begin
                rem <= rem_shift;
                quo <= {quo[N-2:0], 1'b0};
            end
        end
    end

    fifo_array #(.FIFO_DATA_WIDTH(`RAY_WIDTH), .ARRAY_SIZE(1)) u_out_fifo (
        .clock (clock),     .reset (reset),
        .wr_en (out_wr_en), .din   (fifo_din),  .full  (fifo_full),
        .rd_en (out_rd_en), .dout  (fifo_dout), .empty (out_empty)
    );
endmodule

/* p_hit_1.sv */
`include "ray_consts.svh"

module p_hit_fifo_in_pt1 import ray_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  fix_t tri_normal_in [2:0],
    input  fix_t v0_in [2:0],
    input  fix_t origin_in [2:0],
    output logic in_full,
    input  logic in_wr_en,
    output fix_t tri_normal_out [2:0],
    output fix_t v0_out [2:0],
    output fix_t origin_out [2:0],
    output logic in_empty,
    input  logic in_rd_en
);
    fix_t fifo_din [2:0][2:0];
    fix_t fifo_dout [2:0][2:0];
    logic [2:0] full_arr;
    logic [2:0] empty_arr;

    assign fifo_din[0] = tri_normal_in;
    assign fifo_din[1] = v0_in;
    assign fifo_din[2] = origin_in;
    assign tri_normal_out = fifo_dout[0];
    assign v0_out = fifo_dout[1];
    assign origin_out = fifo_dout[2];
    assign in_empty = |empty_arr;  // job ready only when all three are.
    assign in_full = |full_arr;

    for (genvar g = 0; g < 3; g++) begin : g_fifo
        fifo_array #(.FIFO_DATA_WIDTH(`RAY_WIDTH), .ARRAY_SIZE(3)) u_fifo (
            .clock (clock),    .reset (reset),
            .wr_en (in_wr_en), .din   (fifo_din[g]),  .full  (full_arr[g]),
            .rd_en (in_rd_en), .dout  (fifo_dout[g]), .empty (empty_arr[g])
        );
    end
endmodule

module p_hit_dot_add_pt1 import ray_pkg::*; #(
    parameter int Q_BITS = `RAY_Q_BITS
) (
    input  logic clock,
    input  logic reset,
    input  fix_t tri_normal [2:0],
    input  fix_t v0 [2:0],
    input  fix_t origin [2:0],
    output logic in_full,
    input  logic in_wr_en,
    output fix_t out,
    output logic out_empty,
    input  logic out_rd_en
);
    fix_t normal_out [2:0];
    fix_t dot_y [1:0][2:0];
    fix_t dot_out [1:0];
    logic [1:0] dot_rd_en;
    logic [1:0] dot_empty;
    logic in_empty;
    logic sub_rd_en;

    p_hit_fifo_in_pt1 u_p_hit_fifo_in_pt1 (
        .clock          (clock),      .reset      (reset),
        .tri_normal_in  (tri_normal), .v0_in      (v0),       .origin_in  (origin),
        .in_full        (in_full),    .in_wr_en   (in_wr_en),
        .tri_normal_out (normal_out), .v0_out     (dot_y[0]), .origin_out (dot_y[1]),
        .in_empty       (in_empty),   .in_rd_en   (|dot_rd_en)  // both dots pop together.
    );

    // [0] gives n.v0, [1] gives n.o.
    for (genvar g = 0; g < 2; g++) begin : g_dot
        dot #(.Q_BITS(Q_BITS)) u_dot (
            .clock     (clock),        .reset     (reset),
            .x         (normal_out),   .y         (dot_y[g]),
            .in_empty  (in_empty),     .in_rd_en  (dot_rd_en[g]),
            .out       (dot_out[g]),   .out_empty (dot_empty[g]), .out_rd_en (sub_rd_en)
        );
    end

    sub_single u_sub_single (
        .clock     (clock),      .reset     (reset),
        .x         (dot_out[0]), .y         (dot_out[1]),
        .in_empty  (|dot_empty), .in_rd_en  (sub_rd_en),
        .out       (out),        .out_empty (out_empty), .out_rd_en (out_rd_en)
    );
endmodule

module p_hit_dot_pt2 import ray_pkg::*; #(
    parameter int Q_BITS = `RAY_Q_BITS
) (
    input  logic clock,
    input  logic reset,
    input  fix_t tri_normal [2:0],
    input  fix_t dir [2:0],
    output logic in_full,
    input  logic in_wr_en,
    output fix_t out,
    input  logic out_rd_en,
    output logic out_empty
);
    fix_t fifo_din [1:0][2:0];
    fix_t fifo_dout [1:0][2:0];
    logic [1:0] full_arr;
    logic [1:0] empty_arr;
    logic dot_rd_en;

    assign fifo_din[0] = tri_normal;
    assign fifo_din[1] = dir;
    assign in_full = |full_arr;

    for (genvar g = 0; g < 2; g++) begin : g_fifo
        fifo_array #(.FIFO_DATA_WIDTH(`RAY_WIDTH), .ARRAY_SIZE(3)) u_fifo (
            .clock (clock),     .reset (reset),
            .wr_en (in_wr_en),  .din   (fifo_din[g]),  .full  (full_arr[g]),
            .rd_en (dot_rd_en), .dout  (fifo_dout[g]), .empty (empty_arr[g])
        );
    end

    dot #(.Q_BITS(Q_BITS)) u_dot (
        .clock     (clock),        .reset     (reset),
        .x         (fifo_dout[1]), .y         (fifo_dout[0]),  // n.d
        .in_empty  (|empty_arr),   .in_rd_en  (dot_rd_en),
        .out       (out),          .out_empty (out_empty), .out_rd_en (out_rd_en)
    );
endmodule

module p_hit_1 import ray_pkg::*; #(
    parameter int Q_BITS = `RAY_Q_BITS
) (
    input  logic       clock,
    input  logic       reset,
    input  fix_t       tri_normal [2:0],  // feeds both paths.
    input  fix_t       v0 [2:0],
    input  fix_t       origin [2:0],
    input  fix_t       dir [2:0],
    output logic [1:0] in_full,           // [0] numerator, [1] denominator.
    input  logic [1:0] in_wr_en,
    output fix_t       out,
    input  logic       out_rd_en,
    output logic       out_empty
);
    fix_t num;
    fix_t den;
    logic [1:0] path_empty;
    logic div_empty;
    logic div_rd_en;

    assign div_empty = |path_empty;

    p_hit_dot_add_pt1 #(.Q_BITS(Q_BITS)) u_num (
        .clock      (clock),         .reset     (reset),
        .tri_normal (tri_normal),    .v0        (v0),            .origin (origin),
        .in_full    (in_full[0]),    .in_wr_en  (in_wr_en[0]),
        .out        (num),           .out_empty (path_empty[0]), .out_rd_en (div_rd_en)
    );

    p_hit_dot_pt2 #(.Q_BITS(Q_BITS)) u_den (
        .clock      (clock),         .reset     (reset),
        .tri_normal (tri_normal),    .dir       (dir),
        .in_full    (in_full[1]),    .in_wr_en  (in_wr_en[1]),
        .out        (den),           .out_empty (path_empty[1]), .out_rd_en (div_rd_en)
    );

    divide_top #(.Q_BITS(Q_BITS), .D_WIDTH(`RAY_WIDTH)) u_divide_top (
        .clock     (clock),     .reset     (reset),
        .dividend  (num),       .divisor   (den),
        .in_empty  (div_empty), .in_rd_en  (div_rd_en),
        .out_dout  (out),       .out_empty (out_empty), .out_rd_en (out_rd_en)
    );
endmodule

/* tb_p_hit.sv */
`include "ray_consts.svh"

module tb_p_hit import ray_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS   = 12;
    localparam int BP_JOBS = 64;                     // enough to fill every fifo on the way.
    localparam int N_JOBS  = 2 * NROWS + BP_JOBS;
    localparam int LIMIT   = N_JOBS * 80 + 200;

    logic clock;
    logic reset;
    fix_t tri_normal [2:0];
    fix_t v0 [2:0];
    fix_t origin [2:0];
    fix_t dir [2:0];
    logic [1:0] in_full;
    logic [1:0] in_wr_en;
    fix_t out;
    logic out_rd_en;
    logic out_empty;

    fix_t tab [NROWS][4][3];                         // n, v0, o, d per row.
    fix_t exp_q [$];
    string name_q [$];
    int seed;
    int err_count;
    int check_count;
    int job_id;
    int cycle;
    logic drain_en;
    logic pop_next;
    logic saw_full;

    p_hit_1 p_hit_1_i (
        .clock (clock),   .reset (reset),
        .tri_normal (tri_normal), .v0 (v0), .origin (origin), .dir (dir),
        .in_full (in_full), .in_wr_en (in_wr_en),
        .out (out), .out_rd_en (out_rd_en), .out_empty (out_empty)
    );

    always #4 clock = ~clock;

    // full-width products, sum, truncating arithmetic shift.
    function automatic fix_t dot_q(input int row, input int sel);
        longint acc;
        acc = 0;
        for (int i = 0; i < 3; i++) begin
            acc += longint'(tab[row][0][i]) * longint'(tab[row][sel][i]);
        end
        return fix_t'(acc >>> `RAY_Q_BITS);
    endfunction

    function automatic fix_t expected_t(input int row);
        fix_t num;
        fix_t den;
        longint a;
        longint b;
        longint q;
        num = dot_q(row, 1) - dot_q(row, 2);         // wraps at word width.
        den = dot_q(row, 3);
        if (den == 0) begin
            return (num < 0) ? -32'sh7fffffff : 32'sh7fffffff;
        end
        a = (num < 0) ? -longint'(num) : longint'(num);
        b = (den < 0) ? -longint'(den) : longint'(den);
        q = (a <<< `RAY_Q_BITS) / b;                 // truncates toward zero.
        if ((num < 0) != (den < 0)) begin
            q = -q;
            if (q < -64'sh80000000) q = -64'sh80000000;
        end else if (q > 64'sh7fffffff) begin
            q = 64'sh7fffffff;
        end
        return fix_t'(q);
    endfunction

    task automatic put_row(input int r, input int nx, ny, nz, vx, vy, vz,
                           input int ox, oy, oz, dx, dy, dz);
        tab[r][0] = '{nz, ny, nx};
        tab[r][1] = '{vz, vy, vx};
        tab[r][2] = '{oz, oy, ox};
        tab[r][3] = '{dz, dy, dx};
    endtask

    task automatic fill_table;
        put_row(0, 0, 0, 1024, 0, 0, 10240, 0, 0, 0, 0, 0, 2048);
        put_row(1, 1024, 2048, 3072, 4096, 5120, 6144, 1024, 1024, 1024, 1024, 1024, 1024);
        put_row(2, -1024, 2048, -3072, 2048, -1024, 4096, -3072, 1024, 0, 1024, -2048, -1024);
        put_row(3, 1024, 0, 0, 7168, 0, 0, 0, 0, 0, -3072, 0, 0);
        put_row(4, 1024, 0, 0, 5120, 0, 0, 0, 0, 0, 0, 4096, 0);   // zero n.d
        put_row(5, 1024, 0, 0, -5120, 0, 0, 0, 0, 0, 0, 4096, 0);
        put_row(6, 1536, -512, 300, 2000, 3000, -700, 2000, 3000, -700, 0, 0, 0);
        for (int r = 7; r < NROWS; r++) begin
            for (int k = 0; k < 4; k++) begin
                for (int i = 0; i < 3; i++) begin
                    tab[r][k][i] = $random(seed) % 8192;  // about +-8.0 in q10.
                end
            end
        end
    endtask

    // waits for room, then one write strobe on both halves.
    task automatic write_job(input int row, input string tag);
        @(negedge clock);
        while (in_full != 2'b00) begin
            @(posedge clock);
            drain_en <= 1'b1;
            saw_full = 1'b1;
            @(negedge clock);
        end
        @(posedge clock);
        tri_normal <= tab[row][0];
        v0         <= tab[row][1];
        origin     <= tab[row][2];
        dir        <= tab[row][3];
        in_wr_en   <= 2'b11;
        exp_q.push_back(expected_t(row));
        name_q.push_back($sformatf("%s_%0d", tag, job_id));
        job_id++;
        @(posedge clock);
        in_wr_en <= 2'b00;
    endtask

    task automatic wait_drained;
        while (exp_q.size() != 0) @(negedge clock);
    endtask

    task automatic check_result;
        fix_t exp;
        string name;
        if (exp_q.size() == 0) begin
            $display("result %0d came out with no job pending", out);
            err_count++;
        end else begin
            exp = exp_q.pop_front();
            name = name_q.pop_front();
            check_count++;
            if (out !== exp) begin
                $display("[ERROR] %s expected %0d actual %0d", name, exp, out);
                err_count++;
            end
        end
    endtask

    // head is checked in the cycle where out_rd_en is high.
    always @(negedge clock) begin
        pop_next = 1'b0;
        if (!reset && out_rd_en) begin
            check_result();
        end else if (!reset && drain_en && !out_empty) begin
            pop_next = 1'b1;
        end
    end

    always @(posedge clock) begin
        out_rd_en <= pop_next;
    end

    always @(posedge clock) begin
        cycle++;
        if (cycle >= LIMIT) begin
            $display("timeout after %0d cycles with %0d results missing, divider in %s",
                     cycle, exp_q.size(), p_hit_1_i.u_divide_top.state.name());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        tri_normal = '{default: '0};
        v0 = '{default: '0};
        origin = '{default: '0};
        dir = '{default: '0};
        in_wr_en = 2'b00;
        out_rd_en = 1'b0;
        pop_next = 1'b0;
        drain_en = 1'b0;
        saw_full = 1'b0;
        seed = 97991;
        err_count = 0;
        check_count = 0;
        job_id = 0;
        cycle = 0;
        fill_table();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (out_empty !== 1'b1 || in_full !== 2'b00) begin
            $display("[ERROR] reset_state expected out_empty 1 in_full 0 actual %b %b",
                     out_empty, in_full);
            err_count++;
        end
        drain_en <= 1'b1;
        for (int r = 0; r < NROWS; r++) begin
            write_job(r, "single");
            wait_drained();
        end
        for (int r = 0; r < NROWS; r++) begin
            write_job(r, "burst");
        end
        wait_drained();
        @(negedge clock);
        drain_en <= 1'b0;                            // results pile up until in_full rises.
        for (int k = 0; k < BP_JOBS; k++) begin
            write_job(k % NROWS, "backpressure");
        end
        wait_drained();
        if (!saw_full) begin
            $display("in_full never rose while out_rd_en was held low");
            err_count++;
        end
        @(negedge clock);
        if (out_empty !== 1'b1) begin
            $display("a result was left in the output fifo after the last job");
            err_count++;
        end
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule

/* build.f */
+incdir+.
ray_pkg.sv
fifo_array.sv
dot.sv
sub_single.sv
divide_top.sv
p_hit_1.sv
tb_p_hit.sv

/* Bender.yml */
package:
  name: p_hit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ray_pkg.sv
      - fifo_array.sv
      - dot.sv
      - sub_single.sv
      - divide_top.sv
      - p_hit_1.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_p_hit.sv
